// ==== files.f ====
+incdir+design
design/tiny_gpt_pkg.sv
design/param_store.sv
design/embed_stage.sv
design/project_stage.sv
design/residual_stage.sv
design/tiny_gpt_top.sv
verif/tb_tiny_gpt.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f --top-module tb_tiny_gpt -o sim_tiny_gpt

out=$(./obj_dir/sim_tiny_gpt 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1

// ==== verif/tiny_gpt_cases.txt ====
# L addr data | T token gap e0 e1 e2 e3 | N name | R reset, fields in hex
# A gap of FF asks for a random gap of 0 to 3 cycles
N zero_params
T 3 02 0000 0000 0000 0000
T 0 00 0000 0000 0000 0000
N identity
L 04 0400
L 05 FC00
L 06 0200
L 07 1800
L 08 5000
L 09 0001
L 0A C000
L 0B 7FFF
L 40 0400
L 45 0400
L 4A 0400
L 4F 0400
T 1 01 0800 F800 0400 3000
T 2 00 7FFF 0002 8000 7FFF
N signed_weights
L 41 F800
L 4A 0C00
L 4C 0200
L 0C FFFF
L 0F FFFF
T 1 00 1400 F000 0800 3000
T 2 03 DFFF 6002 0000 7FFF
T 3 00 FFFD 0002 0000 FFFE
N stream
T 2 00 DFFF 6002 0000 7FFF
T 1 00 1400 F000 0800 3000
T 3 00 FFFD 0002 0000 FFFE
T 1 FF 1400 F000 0800 3000
T 3 FF FFFD 0002 0000 FFFE
T 2 FF DFFF 6002 0000 7FFF
N saturation
L 10 8000
L 11 9000
L 12 7000
T 4 00 8000 8000 7FFF 0000
N weight_reload
L 41 0000
L 4A 0400
L 4C 0000
T 1 00 0800 F800 0400 3000
T 3 02 FFFE 0000 0000 FFFE
T 4 00 8000 8000 7FFF 0000
R
N after_reset
T 1 01 0000 0000 0000 0000

// ==== verif/tb_tiny_gpt.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "tiny_gpt_config.svh"

module tb_tiny_gpt;

    import tiny_gpt_pkg::*;

    localparam int          CLK_HALF   = 4;
    localparam int          DRIVE_DLY  = 1;     // Inputs change after the edge
    localparam int          PIPE_LAT   = 3;     // Accept edge to out_valid
    localparam logic [31:0] SEED       = 32'h6261_75c6;
    localparam string       CASES_FILE = "verif/tiny_gpt_cases.txt";

    logic        clk = 1'b0;
    logic        rst_n;
    logic        param_we;
    param_addr_t param_addr;
    elem_t       param_wdata;
    logic        token_valid;
    token_t      token;
    logic        out_valid;
    row_t        out_row;

    int          cycle_cnt       = 0;
    int          watchdog_cycles = 0;
    string       cur_test        = "none";

    // Records as read from the cases file
    string       rec_kind [$];
    string       rec_name [$];
    logic [31:0] rec_a    [$];
    logic [31:0] rec_b    [$];
    row_t        rec_row  [$];

    // Tokens in flight, oldest first
    row_t        exp_row_q   [$];
    int          exp_cycle_q [$];
    string       exp_test_q  [$];

    tiny_gpt_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .param_we    (param_we),
        .param_addr  (param_addr),
        .param_wdata (param_wdata),
        .token_valid (token_valid),
        .token       (token),
        .out_valid   (out_valid),
        .out_row     (out_row)
    );

    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ======================================================================
    // Error handling and checks
    // ======================================================================
    task automatic stop_with_failure();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        stop_with_failure();
    endtask

    task automatic compare_value(input string test_name, input int elem,
                                 input logic [`TG_ELEM_W-1:0] expected,
                                 input logic [`TG_ELEM_W-1:0] actual);
        if (actual !== expected) begin
            $display("Fail %s element %0d: expected %04h, actual %04h",
                     test_name, elem, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_output();
        row_t  expected;
        int    accepted;
        string test_name;
        if (exp_row_q.size() == 0) begin
            report_error("out_valid went high with no token in flight");
        end else begin
            expected  = exp_row_q.pop_front();
            accepted  = exp_cycle_q.pop_front();
            test_name = exp_test_q.pop_front();
            // A consumer takes the output at the coming edge
            if (cycle_cnt + 1 != accepted + PIPE_LAT) begin
                report_error($sformatf("a token of %s came out %0d cycles after acceptance",
                                       test_name, cycle_cnt + 1 - accepted));
            end else begin
                for (int e = 0; e < `TG_D_MODEL; e++) begin
                    compare_value(test_name, e, expected[e], out_row[e]);
                end
            end
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            check_output();
        end else if (exp_cycle_q.size() != 0 && cycle_cnt + 1 > exp_cycle_q[0] + PIPE_LAT) begin
            report_error($sformatf("a token of %s never reached the output", exp_test_q[0]));
        end
    end

    // ======================================================================
    // Stimulus
    // ======================================================================
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic drain_pipe();
        while (exp_row_q.size() != 0) begin
            next_cycle();
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (3) next_cycle();
        rst_n = 1'b1;
    endtask

    task automatic load_param(input logic [31:0] addr, input logic [31:0] data);
        drain_pipe();  // Weights feed stage 2 directly
        param_we    = 1'b1;
        param_addr  = addr[`TG_ADDR_W-1:0];
        param_wdata = data[`TG_ELEM_W-1:0];
        next_cycle();
        param_we    = 1'b0;
    endtask

    task automatic send_token(input token_t tok, input int gap, input row_t expected);
        repeat (gap) next_cycle();
        token_valid = 1'b1;
        token       = tok;
        exp_row_q.push_back(expected);
        exp_cycle_q.push_back(cycle_cnt + 1);  // Taken at the coming edge
        exp_test_q.push_back(cur_test);
        next_cycle();
        token_valid = 1'b0;
    endtask

    task automatic read_cases();
        int                   fd;
        int                   n;
        int                   want;
        string                kind;
        string                name;
        string                line;
        logic [31:0]          f0;
        logic [31:0]          f1;
        logic [`TG_ELEM_W-1:0] e0;
        logic [`TG_ELEM_W-1:0] e1;
        logic [`TG_ELEM_W-1:0] e2;
        logic [`TG_ELEM_W-1:0] e3;
        row_t                 row;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            report_error("cannot open the cases file");
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                name = "";
                f0   = '0;
                f1   = '0;
                row  = '0;
                n    = 0;
                if (kind == "#") begin
                    n = $fgets(line, fd);  // Comment line
                end else begin
                    if (kind == "L") begin
                        want = 2;
                        n    = $fscanf(fd, "%h %h", f0, f1);
                    end else if (kind == "T") begin
                        want = 6;
                        n    = $fscanf(fd, "%h %h %h %h %h %h", f0, f1, e0, e1, e2, e3);
                        row  = {e3, e2, e1, e0};
                    end else if (kind == "N") begin
                        want = 1;
                        n    = $fscanf(fd, "%s", name);
                    end else if (kind == "R") begin
                        want = 0;
                    end else begin
                        want = -1;
                    end
                    if (n != want) begin
                        report_error($sformatf("bad record of kind %s in the cases file", kind));
                    end else begin
                        rec_kind.push_back(kind);
                        rec_name.push_back(name);
                        rec_a.push_back(f0);
                        rec_b.push_back(f1);
                        rec_row.push_back(row);
                    end
                end
            end
            $fclose(fd);
            watchdog_cycles = rec_kind.size() * 8 + 50;
        end
    endtask

    // ======================================================================
    // Main sequence and watchdog
    // ======================================================================
    initial begin
        int gap;
        rst_n       = 1'b0;
        param_we    = 1'b0;
        param_addr  = '0;
        param_wdata = '0;
        token_valid = 1'b0;
        token       = '0;
        void'($urandom(SEED));
        read_cases();
        apply_reset();
        for (int i = 0; i < rec_kind.size(); i++) begin
            if (rec_kind[i] == "N") begin
                cur_test = rec_name[i];
            end else if (rec_kind[i] == "R") begin
                drain_pipe();
                apply_reset();
            end else if (rec_kind[i] == "L") begin
                load_param(rec_a[i], rec_b[i]);
            end else begin
                gap = (rec_b[i] == 32'hFF) ? int'($urandom % 4) : int'(rec_b[i]);
                send_token(rec_a[i][`TG_TOKEN_W-1:0], gap, rec_row[i]);
            end
        end
        repeat (PIPE_LAT + 1) next_cycle();  // Last token reaches the output
        if (exp_row_q.size() != 0) begin
            report_error("tokens still in flight at the end of the run");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        report_error("timeout, the run did not finish in time");
    end

endmodule

`default_nettype wire

// ==== design/tiny_gpt_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module tiny_gpt_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      param_we,
    input  tiny_gpt_pkg::param_addr_t param_addr,
    input  tiny_gpt_pkg::elem_t       param_wdata,
    input  logic                      token_valid,
    input  tiny_gpt_pkg::token_t      token,
    output logic                      out_valid,
    output tiny_gpt_pkg::row_t        out_row
);

    import tiny_gpt_pkg::*;

    // Store to embed lookup
    token_t      lookup_token;
    row_t        lookup_row;
    weight_mat_t weight_mat;

    // Between stages
    logic        emb_valid;
    row_t        emb_row;
    logic        proj_valid;
    row_t        proj_row;
    row_t        skip_row;

    // ======================================================================
    // Parameters and pipeline, in stage order
    // ======================================================================
    param_store i_param_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .param_we     (param_we),
        .param_addr   (param_addr),
        .param_wdata  (param_wdata),
        .lookup_token (lookup_token),
        .lookup_row   (lookup_row),
        .weight_mat   (weight_mat)
    );

    embed_stage i_embed_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .token_valid  (token_valid),
        .token        (token),
        .lookup_token (lookup_token),
        .lookup_row   (lookup_row),
        .emb_valid    (emb_valid),
        .emb_row      (emb_row)
    );

    project_stage i_project_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .emb_valid    (emb_valid),
        .emb_row      (emb_row),
        .weight_mat   (weight_mat),
        .proj_valid   (proj_valid),
        .proj_row     (proj_row),
        .skip_row     (skip_row)
    );

    residual_stage i_residual_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .proj_valid   (proj_valid),
        .proj_row     (proj_row),
        .skip_row     (skip_row),
        .out_valid    (out_valid),
        .out_row      (out_row)
    );

endmodule

`default_nettype wire

// ==== design/residual_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "tiny_gpt_config.svh"

module residual_stage (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               proj_valid,
    input  tiny_gpt_pkg::row_t proj_row,
    input  tiny_gpt_pkg::row_t skip_row,
    output logic               out_valid,
    output tiny_gpt_pkg::row_t out_row
);

    import tiny_gpt_pkg::*;

    localparam elem_t ELEM_MAX = {1'b0, {(`TG_ELEM_W-1){1'b1}}};  // 32767
    localparam elem_t ELEM_MIN = {1'b1, {(`TG_ELEM_W-1){1'b0}}};  // -32768

    logic signed [`TG_ELEM_W:0] lane_sum [`TG_D_MODEL];
    row_t                       sat_row;

    // ======================================================================
    // Lane adders with clamp
    // ======================================================================
    always_comb begin
        for (int i = 0; i < `TG_D_MODEL; i++) begin
            lane_sum[i] = {skip_row[i][`TG_ELEM_W-1], skip_row[i]}
                        + {proj_row[i][`TG_ELEM_W-1], proj_row[i]};
            // Guard bit disagrees with sign bit on overflow
            if (lane_sum[i][`TG_ELEM_W] != lane_sum[i][`TG_ELEM_W-1]) begin
                sat_row[i] = lane_sum[i][`TG_ELEM_W] ? ELEM_MIN : ELEM_MAX;
            end else begin
                sat_row[i] = lane_sum[i][`TG_ELEM_W-1:0];
            end
        end
    end

    // ======================================================================
    // Stage 3 register
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= proj_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (proj_valid) begin
            out_row <= sat_row;
        end
    end

endmodule

`default_nettype wire

// ==== design/project_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "tiny_gpt_config.svh"

module project_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      emb_valid,
    input  tiny_gpt_pkg::row_t        emb_row,
    input  tiny_gpt_pkg::weight_mat_t weight_mat,
    output logic                      proj_valid,
    output tiny_gpt_pkg::row_t        proj_row,
    output tiny_gpt_pkg::row_t        skip_row
);

    import tiny_gpt_pkg::*;

    localparam int PROD_W = 2 * `TG_ELEM_W;
    localparam int ACC_W  = PROD_W + 2;     // Room for four terms

    logic signed [PROD_W-1:0] prod [`TG_D_MODEL][`TG_D_MODEL];
    logic signed [ACC_W-1:0]  acc  [`TG_D_MODEL];
    logic signed [ACC_W-1:0]  acc_shr [`TG_D_MODEL];
    row_t                     col_out;

    // ======================================================================
    // Column dot products
    // ======================================================================
    always_comb begin
        for (int c = 0; c < `TG_D_MODEL; c++) begin
            acc[c] = '0;
            for (int k = 0; k < `TG_D_MODEL; k++) begin
                // Full width signed product, Q10.20
                prod[k][c] = $signed(emb_row[k]) * $signed(weight_mat[k][c]);
                acc[c]     = acc[c] + prod[k][c];
            end
        end
    end

    // Back to Q5.10, high bits simply wrap
    always_comb begin
        for (int c = 0; c < `TG_D_MODEL; c++) begin
            acc_shr[c] = acc[c] >>> `TG_FRAC_W;
            col_out[c] = acc_shr[c][`TG_ELEM_W-1:0];
        end
    end

    // ======================================================================
    // Stage 2 register
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            proj_valid <= 1'b0;
        end else begin
            proj_valid <= emb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (emb_valid) begin
            proj_row <= col_out;
            skip_row <= emb_row;  // Residual path, same latency as proj_row
        end
    end

endmodule

`default_nettype wire

// ==== design/embed_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module embed_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 token_valid,
    input  tiny_gpt_pkg::token_t token,
    output tiny_gpt_pkg::token_t lookup_token,
    input  tiny_gpt_pkg::row_t   lookup_row,
    output logic                 emb_valid,
    output tiny_gpt_pkg::row_t   emb_row
);

    import tiny_gpt_pkg::*;

    // Store answers in the same cycle
    assign lookup_token = token;

    // ======================================================================
    // Stage 1 register
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            emb_valid <= 1'b0;
        end else begin
            emb_valid <= token_valid;
        end
    end

    // Row is frozen here for the rest of the pipe
    always_ff @(posedge clk) begin
        if (token_valid) begin
            emb_row <= lookup_row;
        end
    end

endmodule

`default_nettype wire

// ==== design/param_store.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "tiny_gpt_config.svh"

module param_store (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      param_we,
    input  tiny_gpt_pkg::param_addr_t param_addr,
    input  tiny_gpt_pkg::elem_t       param_wdata,
    input  tiny_gpt_pkg::token_t      lookup_token,
    output tiny_gpt_pkg::row_t        lookup_row,
    output tiny_gpt_pkg::weight_mat_t weight_mat
);

    import tiny_gpt_pkg::*;

    elem_t mem [`TG_PARAM_DEPTH];

    // ======================================================================
    // Load port
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `TG_PARAM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (param_we && (int'(param_addr) < `TG_PARAM_DEPTH)) begin
            mem[param_addr] <= param_wdata;  // Addresses past the top are dropped
        end
    end

    // ======================================================================
    // Read side, all combinational
    // ======================================================================

    // Four consecutive entries form one embedding row
    always_comb begin
        for (int c = 0; c < `TG_D_MODEL; c++) begin
            lookup_row[c] = mem[`TG_EMB_BASE + int'(lookup_token) * `TG_D_MODEL + c];
        end
    end

    // Whole projection matrix, row major from the weight base
    always_comb begin
        for (int k = 0; k < `TG_D_MODEL; k++) begin
            for (int c = 0; c < `TG_D_MODEL; c++) begin
                weight_mat[k][c] = mem[`TG_W_BASE + k * `TG_D_MODEL + c];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/tiny_gpt_pkg.sv ====
`default_nettype none

package tiny_gpt_pkg;

    `include "tiny_gpt_config.svh"

    // One signed Q5.10 value
    typedef logic signed [`TG_ELEM_W-1:0] elem_t;

    // Element 0 sits in the low bits
    typedef elem_t [`TG_D_MODEL-1:0] row_t;

    // Indexed as [k][c], k picks the input element
    typedef row_t [`TG_D_MODEL-1:0] weight_mat_t;

    typedef logic [`TG_TOKEN_W-1:0] token_t;

    // Covers both the embedding table and the weights
    typedef logic [`TG_ADDR_W-1:0] param_addr_t;

endpackage

`default_nettype wire

// ==== design/tiny_gpt_config.svh ====
`ifndef TINY_GPT_CONFIG_SVH
`define TINY_GPT_CONFIG_SVH

// ==========================================================================
// Model sizes
// ==========================================================================
`define TG_VOCAB        16      // Tokens in the vocabulary
`define TG_D_MODEL      4       // Elements per row
`define TG_ELEM_W       16      // Q5.10 element
`define TG_FRAC_W       10
`define TG_TOKEN_W      4

// ==========================================================================
// Parameter memory map
// ==========================================================================
// Embedding entry is token * D_MODEL + column
`define TG_EMB_BASE     0
// Weight entry is row * D_MODEL + column, offset by the base
`define TG_W_BASE       64
`define TG_PARAM_DEPTH  80
`define TG_ADDR_W       7

`endif
